// File: src/cpu_pkg.sv
// Shared definitions for the 8-bit core
// ALU select, register-file write select, opcode groups, instruction word
`default_nettype none

package cpu_pkg;

	localparam int INSTR_W = 18;	// Fixed by the encoding

	// ALU operation select, values follow the original decoder
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_ADDC = 4'd1,
		ALU_SUB  = 4'd2,
		ALU_SUBC = 4'd3,
		ALU_CMP  = 4'd4,
		ALU_AND  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_EXOR = 4'd7,
		ALU_TEST = 4'd8,
		ALU_LSL  = 4'd9,
		ALU_LSR  = 4'd10,
		ALU_ROL  = 4'd11,
		ALU_ROR  = 4'd12,
		ALU_ASR  = 4'd13,
		ALU_MOV  = 4'd14
	} alu_sel_t;

	typedef enum logic {
		RF_SEL_ALU = 1'b0,	// ALU result
		RF_SEL_IN  = 1'b1	// in_port
	} rf_wr_sel_t;

	//////////////////////////////////////////////////
	// op_hi groups
	//////////////////////////////////////////////////
	localparam logic [4:0] OP_LOGIC_RR = 5'b000_00;	// AND OR EXOR TEST by op_lo
	localparam logic [4:0] OP_ARITH_RR = 5'b000_01;	// ADD ADDC SUB SUBC by op_lo
	localparam logic [4:0] OP_CMPMOV_RR = 5'b000_10;	// CMP MOV by op_lo
	localparam logic [4:0] OP_BRANCH_A = 5'b001_00;	// BRN BREQ BRNE
	localparam logic [4:0] OP_BRANCH_B = 5'b001_01;	// BRCS BRCC
	localparam logic [4:0] OP_SHIFT_A = 5'b010_00;	// LSL LSR ROL ROR
	localparam logic [4:0] OP_SHIFT_B = 5'b010_01;	// ASR
	localparam logic [4:0] OP_CARRY = 5'b011_00;	// CLC SEC
	localparam logic [4:0] OP_AND_I = 5'b100_00;
	localparam logic [4:0] OP_OR_I = 5'b100_01;
	localparam logic [4:0] OP_EXOR_I = 5'b100_10;
	localparam logic [4:0] OP_TEST_I = 5'b100_11;
	localparam logic [4:0] OP_ADD_I = 5'b101_00;
	localparam logic [4:0] OP_ADDC_I = 5'b101_01;
	localparam logic [4:0] OP_SUB_I = 5'b101_10;
	localparam logic [4:0] OP_SUBC_I = 5'b101_11;
	localparam logic [4:0] OP_CMP_I = 5'b110_00;
	localparam logic [4:0] OP_IN = 5'b110_01;
	localparam logic [4:0] OP_OUT = 5'b110_10;
	localparam logic [4:0] OP_MOV_I = 5'b110_11;

	// One 18-bit word, three views
	typedef union packed {
		struct packed {
			logic [4:0] op_hi;
			logic [4:0] rx;
			logic [4:0] ry;
			logic       rsvd;
			logic [1:0] op_lo;
		} reg_reg;
		struct packed {
			logic [4:0] op_hi;
			logic [4:0] rx;
			logic [7:0] imm;
		} reg_imm;
		struct packed {
			logic [4:0] op_hi;
			logic [9:0] addr;
			logic       rsvd;
			logic [1:0] op_lo;
		} branch;
	} instr_t;

endpackage

`default_nettype wire

// File: src/cpu_ctrl_if.sv
// Control bus from the control unit to PC, register file and ALU
`timescale 1ns/1ps
`default_nettype none

interface cpu_ctrl_if;

	logic pc_ld;	// Branch load
	logic pc_inc;	// Step after fetch
	logic ir_ld;	// Instruction register load
	logic alu_opy_sel;	// 0 = dy, 1 = imm
	cpu_pkg::alu_sel_t alu_sel;
	logic rf_wr;
	cpu_pkg::rf_wr_sel_t rf_wr_sel;
	logic flg_c_set;
	logic flg_c_clr;
	logic flg_c_ld;
	logic flg_z_ld;
	logic io_strb;	// One cycle per OUT

	modport ctrl (
		output pc_ld, pc_inc, ir_ld, alu_opy_sel, alu_sel, rf_wr, rf_wr_sel,
		output flg_c_set, flg_c_clr, flg_c_ld, flg_z_ld, io_strb
	);

	modport pc (input pc_ld, pc_inc);

	modport rf (input rf_wr, rf_wr_sel);

	modport alu (
		input alu_opy_sel, alu_sel, flg_c_set, flg_c_clr, flg_c_ld, flg_z_ld
	);

endinterface

`default_nettype wire

// File: src/control_unit.sv
// Control unit: INIT/FETCH/EXEC state machine, instruction register
// and opcode decoder driving the control bus
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  logic                         CLK,
	input  logic                         RESET,
	input  logic [cpu_pkg::INSTR_W-1:0]  instr_word,
	input  logic                         c_flag,
	input  logic                         z_flag,
	cpu_ctrl_if.ctrl                     ctrl,
	output logic [4:0]                   rx,
	output logic [4:0]                   ry,
	output logic [7:0]                   imm,
	output logic [9:0]                   br_addr
);

	typedef enum logic [1:0] {ST_INIT, ST_FETCH, ST_EXEC} state_t;

	state_t state, next_state;
	cpu_pkg::instr_t ir;
	logic [4:0] op_hi;
	logic [1:0] op_lo;

	always_ff @(posedge CLK)
	begin
		if (RESET)
			state <= ST_INIT;
		else
			state <= next_state;
	end

	always_ff @(posedge CLK)
	begin
		if (ctrl.ir_ld)
			ir <= instr_word;	// Word at the PC, during FETCH
	end

	assign op_hi = ir.reg_reg.op_hi;
	assign op_lo = ir.reg_reg.op_lo;
	assign rx = ir.reg_reg.rx;
	assign ry = ir.reg_reg.ry;
	assign imm = ir.reg_imm.imm;
	assign br_addr = ir.branch.addr;

	//////////////////////////////////////////////////
	// Next state and strobe decode
	//////////////////////////////////////////////////
	always_comb
	begin
		ctrl.pc_ld = 1'b0;
		ctrl.pc_inc = 1'b0;
		ctrl.ir_ld = 1'b0;
		ctrl.alu_opy_sel = 1'b0;
		ctrl.alu_sel = cpu_pkg::ALU_ADD;
		ctrl.rf_wr = 1'b0;
		ctrl.rf_wr_sel = cpu_pkg::RF_SEL_ALU;
		ctrl.flg_c_set = 1'b0;
		ctrl.flg_c_clr = 1'b0;
		ctrl.flg_c_ld = 1'b0;
		ctrl.flg_z_ld = 1'b0;
		ctrl.io_strb = 1'b0;
		next_state = ST_FETCH;

		case (state)
			ST_INIT: next_state = ST_FETCH;	// PC and flags already cleared by RESET
			ST_FETCH:
			begin
				ctrl.ir_ld = 1'b1;
				ctrl.pc_inc = 1'b1;
				next_state = ST_EXEC;
			end
			ST_EXEC:
			begin
				case (op_hi)
					cpu_pkg::OP_LOGIC_RR:
					begin
						ctrl.flg_c_clr = 1'b1;
						ctrl.flg_z_ld = 1'b1;
						ctrl.rf_wr = (op_lo != 2'b11);	// TEST leaves rx alone
						ctrl.alu_sel = cpu_pkg::alu_sel_t'(4'd5 + {2'b00, op_lo});
					end
					cpu_pkg::OP_ARITH_RR:
					begin
						ctrl.flg_c_ld = 1'b1;
						ctrl.flg_z_ld = 1'b1;
						ctrl.rf_wr = 1'b1;
						ctrl.alu_sel = cpu_pkg::alu_sel_t'({2'b00, op_lo});	// ADD..SUBC
					end
					cpu_pkg::OP_CMPMOV_RR:
					begin
						if (op_lo == 2'b00)	// CMP
						begin
							ctrl.alu_sel = cpu_pkg::ALU_CMP;
							ctrl.flg_c_ld = 1'b1;
							ctrl.flg_z_ld = 1'b1;
						end
						else if (op_lo == 2'b01)	// MOV rx, ry
						begin
							ctrl.alu_sel = cpu_pkg::ALU_MOV;
							ctrl.rf_wr = 1'b1;
						end
					end
					cpu_pkg::OP_AND_I, cpu_pkg::OP_OR_I, cpu_pkg::OP_EXOR_I,
					cpu_pkg::OP_TEST_I:
					begin
						ctrl.flg_c_clr = 1'b1;
						ctrl.flg_z_ld = 1'b1;
						ctrl.alu_opy_sel = 1'b1;
						ctrl.rf_wr = (op_hi != cpu_pkg::OP_TEST_I);
						ctrl.alu_sel = cpu_pkg::alu_sel_t'(4'd5 + {2'b00, op_hi[1:0]});
					end
					cpu_pkg::OP_ADD_I, cpu_pkg::OP_ADDC_I, cpu_pkg::OP_SUB_I,
					cpu_pkg::OP_SUBC_I:
					begin
						ctrl.flg_c_ld = 1'b1;
						ctrl.flg_z_ld = 1'b1;
						ctrl.alu_opy_sel = 1'b1;
						ctrl.rf_wr = 1'b1;
						ctrl.alu_sel = cpu_pkg::alu_sel_t'({2'b00, op_hi[1:0]});
					end
					cpu_pkg::OP_CMP_I:
					begin
						ctrl.flg_c_ld = 1'b1;
						ctrl.flg_z_ld = 1'b1;
						ctrl.alu_opy_sel = 1'b1;
						ctrl.alu_sel = cpu_pkg::ALU_CMP;
					end
					cpu_pkg::OP_IN:
					begin
						ctrl.rf_wr_sel = cpu_pkg::RF_SEL_IN;	// in_port sampled this cycle
						ctrl.rf_wr = 1'b1;
					end
					cpu_pkg::OP_OUT: ctrl.io_strb = 1'b1;
					cpu_pkg::OP_MOV_I:
					begin
						ctrl.alu_opy_sel = 1'b1;
						ctrl.alu_sel = cpu_pkg::ALU_MOV;
						ctrl.rf_wr = 1'b1;
					end
					cpu_pkg::OP_BRANCH_A:	// BRN, BREQ, BRNE; op_lo 01 is CALL, not decoded
						ctrl.pc_ld = (op_lo == 2'b00) || (op_lo == 2'b10 && z_flag)
							|| (op_lo == 2'b11 && !z_flag);
					cpu_pkg::OP_BRANCH_B:	// BRCS, BRCC
						ctrl.pc_ld = (op_lo == 2'b00 && c_flag) || (op_lo == 2'b01 && !c_flag);
					cpu_pkg::OP_SHIFT_A:
					begin
						ctrl.rf_wr = 1'b1;
						ctrl.flg_c_ld = 1'b1;	// Bit shifted out
						ctrl.flg_z_ld = 1'b1;
						ctrl.alu_sel = cpu_pkg::alu_sel_t'(4'd9 + {2'b00, op_lo});	// LSL..ROR
					end
					cpu_pkg::OP_SHIFT_B:
					begin
						ctrl.rf_wr = (op_lo == 2'b00);	// ASR only, PUSH/POP dropped
						ctrl.flg_c_ld = (op_lo == 2'b00);
						ctrl.flg_z_ld = (op_lo == 2'b00);
						ctrl.alu_sel = cpu_pkg::ALU_ASR;
					end
					cpu_pkg::OP_CARRY:
					begin
						ctrl.flg_c_clr = (op_lo == 2'b00);	// CLC
						ctrl.flg_c_set = (op_lo == 2'b01);	// SEC
					end
					default: ;	// Anything else is a no-op
				endcase
				next_state = ST_FETCH;
			end
			default: next_state = ST_INIT;
		endcase
	end

	// Increment belongs to FETCH, load to EXEC
	a_pc_one_source: assert property (@(posedge CLK) disable iff (RESET)
		!(ctrl.pc_ld && ctrl.pc_inc))
		else $error("pc_ld and pc_inc high together");

endmodule

`default_nettype wire

// File: src/program_counter.sv
// Program counter with branch load and increment
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
	parameter int PROG_ADDR_W = 10
) (
	input  logic                   CLK,
	input  logic                   RESET,
	cpu_ctrl_if.pc                 ctrl,
	input  logic [9:0]             br_addr,
	output logic [PROG_ADDR_W-1:0] pc
);

	logic [PROG_ADDR_W-1:0] pc_next;

	// Load/increment mux
	always_comb
	begin
		pc_next = pc;
		if (ctrl.pc_ld)
			pc_next = br_addr[PROG_ADDR_W-1:0];	// Target truncated to memory size
		else if (ctrl.pc_inc)
			pc_next = pc + PROG_ADDR_W'(1);
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
			pc <= '0;
		else
			pc <= pc_next;
	end

endmodule

`default_nettype wire

// File: src/prog_mem.sv
// Program memory, synchronous write port and combinational read port
`timescale 1ns/1ps
`default_nettype none

module prog_mem #(
	parameter int PROG_ADDR_W = 10
) (
	input  logic                        CLK,
	input  logic                        we,
	input  logic [PROG_ADDR_W-1:0]      waddr,
	input  logic [PROG_ADDR_W-1:0]      raddr,
	input  logic [cpu_pkg::INSTR_W-1:0] wdata,
	output logic [cpu_pkg::INSTR_W-1:0] rdata
);

	localparam int DEPTH = 1 << PROG_ADDR_W;

	logic [cpu_pkg::INSTR_W-1:0] mem [DEPTH];

	// Loader port, write enable gated by RESET at the top
	always_ff @(posedge CLK)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rdata = mem[raddr];	// Fetch path, no latency

endmodule

`default_nettype wire

// File: src/reg_file.sv
// Register file: 32 x 8, two read ports, one write port
// with ALU / in_port write-data mux
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic       CLK,
	cpu_ctrl_if.rf     ctrl,
	input  logic [4:0] rx,
	input  logic [4:0] ry,
	input  logic [7:0] alu_result,
	input  logic [7:0] in_port,
	output logic [7:0] dx,
	output logic [7:0] dy
);

	logic [7:0] regs [32];
	logic [7:0] wdata;

	// Write source
	assign wdata = (ctrl.rf_wr_sel == cpu_pkg::RF_SEL_IN) ? in_port : alu_result;

	always_ff @(posedge CLK)
	begin
		if (ctrl.rf_wr)
			regs[rx] <= wdata;	// Destination is always rx
	end

	// Async reads
	assign dx = regs[rx];
	assign dy = regs[ry];

endmodule

`default_nettype wire

// File: src/alu_unit.sv
// ALU with operand-Y mux and the C/Z flag registers
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input  logic       CLK,
	input  logic       RESET,
	cpu_ctrl_if.alu    ctrl,
	input  logic [7:0] dx,
	input  logic [7:0] dy,
	input  logic [7:0] imm,
	output logic [7:0] result,
	output logic       c_flag,
	output logic       z_flag
);

	logic [7:0] opy;
	logic c_next;
	logic z_next;

	assign opy = ctrl.alu_opy_sel ? imm : dy;	// Immediate forms

	//////////////////////////////////////////////////
	// Operations
	//////////////////////////////////////////////////
	always_comb
	begin
		result = dx;
		c_next = c_flag;	// Held unless the op makes a new one
		case (ctrl.alu_sel)
			cpu_pkg::ALU_ADD:  {c_next, result} = {1'b0, dx} + {1'b0, opy};
			cpu_pkg::ALU_ADDC: {c_next, result} = {1'b0, dx} + {1'b0, opy} + {8'd0, c_flag};
			// Bit 8 of the difference is the borrow
			cpu_pkg::ALU_SUB:  {c_next, result} = {1'b0, dx} - {1'b0, opy};
			cpu_pkg::ALU_SUBC: {c_next, result} = {1'b0, dx} - {1'b0, opy} - {8'd0, c_flag};
			cpu_pkg::ALU_CMP:  {c_next, result} = {1'b0, dx} - {1'b0, opy};
			cpu_pkg::ALU_AND:  result = dx & opy;
			cpu_pkg::ALU_OR:   result = dx | opy;
			cpu_pkg::ALU_EXOR: result = dx ^ opy;
			cpu_pkg::ALU_TEST: result = dx & opy;	// Flags only
			// Shifts, bit shifted out lands in c_next
			cpu_pkg::ALU_LSL:  {c_next, result} = {dx, 1'b0};
			cpu_pkg::ALU_LSR:  {result, c_next} = {1'b0, dx};
			cpu_pkg::ALU_ROL:  {c_next, result} = {dx, dx[7]};
			cpu_pkg::ALU_ROR:  {result, c_next} = {dx[0], dx};
			cpu_pkg::ALU_ASR:  {result, c_next} = {dx[7], dx};	// Sign kept
			cpu_pkg::ALU_MOV:  result = opy;
			default: ;
		endcase
	end

	assign z_next = (result == 8'd0);

	//////////////////////////////////////////////////
	// Flags
	//////////////////////////////////////////////////
	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			c_flag <= 1'b0;
			z_flag <= 1'b0;
		end
		else
		begin
			if (ctrl.flg_c_set)
				c_flag <= 1'b1;	// SEC
			else if (ctrl.flg_c_clr)
				c_flag <= 1'b0;	// CLC and logic ops
			else if (ctrl.flg_c_ld)
				c_flag <= c_next;
			if (ctrl.flg_z_ld)
				z_flag <= z_next;
		end
	end

	// Decoder never asks for both in one EXEC
	a_c_set_clr: assert property (@(posedge CLK) disable iff (RESET)
		!(ctrl.flg_c_set && ctrl.flg_c_clr))
		else $error("flg_c_set and flg_c_clr high together");

endmodule

`default_nettype wire

// File: src/rat_cpu.sv
// Top level of the 8-bit core
// Control unit, PC, program memory, register file and ALU
`timescale 1ns/1ps
`default_nettype none

module rat_cpu #(
	parameter int PROG_ADDR_W = 10
) (
	input  logic                        CLK,
	input  logic                        RESET,
	input  logic                        prog_we,
	input  logic [PROG_ADDR_W-1:0]      prog_addr,
	input  logic [cpu_pkg::INSTR_W-1:0] prog_data,
	input  logic [7:0]                  in_port,
	output logic [7:0]                  out_port,
	output logic [7:0]                  port_id,
	output logic                        io_strb
);

	cpu_ctrl_if ctrl_bus ();

	logic [PROG_ADDR_W-1:0] pc;
	logic [cpu_pkg::INSTR_W-1:0] instr_word;
	logic prog_we_rst;	// Loader writes only while held in reset
	logic [4:0] rx;
	logic [4:0] ry;
	logic [7:0] imm;
	logic [9:0] br_addr;
	logic [7:0] dx;
	logic [7:0] dy;
	logic [7:0] alu_result;
	logic c_flag;
	logic z_flag;

	assign prog_we_rst = prog_we & RESET;
	assign out_port = dx;	// Register rx
	assign port_id = imm;
	assign io_strb = ctrl_bus.io_strb;

	control_unit control_unit_inst (
		.CLK        (CLK),
		.RESET      (RESET),
		.instr_word (instr_word),
		.c_flag     (c_flag),
		.z_flag     (z_flag),
		.ctrl       (ctrl_bus.ctrl),
		.rx         (rx),
		.ry         (ry),
		.imm        (imm),
		.br_addr    (br_addr)
	);

	program_counter #(.PROG_ADDR_W(PROG_ADDR_W)) program_counter_inst (
		.CLK     (CLK),
		.RESET   (RESET),
		.ctrl    (ctrl_bus.pc),
		.br_addr (br_addr),
		.pc      (pc)
	);

	prog_mem #(.PROG_ADDR_W(PROG_ADDR_W)) prog_mem_inst (
		.CLK   (CLK),
		.we    (prog_we_rst),
		.waddr (prog_addr),
		.raddr (pc),
		.wdata (prog_data),
		.rdata (instr_word)
	);

	reg_file reg_file_inst (
		.CLK        (CLK),
		.ctrl       (ctrl_bus.rf),
		.rx         (rx),
		.ry         (ry),
		.alu_result (alu_result),
		.in_port    (in_port),
		.dx         (dx),
		.dy         (dy)
	);

	alu_unit alu_unit_inst (
		.CLK    (CLK),
		.RESET  (RESET),
		.ctrl   (ctrl_bus.alu),
		.dx     (dx),
		.dy     (dy),
		.imm    (imm),
		.result (alu_result),
		.c_flag (c_flag),
		.z_flag (z_flag)
	);

endmodule

`default_nettype wire

// File: testbench/rat_cpu_tb.sv
// Testbench for the 8-bit core
// Program assembly and load helpers, strobe capture, directed tests
`timescale 1ns/1ps
`default_nettype none

module rat_cpu_tb;

	localparam int PROG_ADDR_W = 10;
	localparam int CLK_HALF = 4;	// 8 ns period
	localparam int TAIL_CYCLES = 16;	// Watch for stray strobes at the end
	// Longest program about 115 words: load + 2 cycles per word + tail,
	// under 400 cycles each, five programs
	localparam int TIMEOUT_CYCLES = 2000;

	localparam logic [4:0] ARITH_IMM_OPS [4] = '{cpu_pkg::OP_ADD_I, cpu_pkg::OP_ADDC_I,
		cpu_pkg::OP_SUB_I, cpu_pkg::OP_SUBC_I};
	localparam logic [4:0] LOGIC_IMM_OPS [4] = '{cpu_pkg::OP_AND_I, cpu_pkg::OP_OR_I,
		cpu_pkg::OP_EXOR_I, cpu_pkg::OP_TEST_I};

	logic CLK;
	logic RESET;
	logic prog_we;
	logic [PROG_ADDR_W-1:0] prog_addr;
	logic [17:0] prog_data;
	logic [7:0] in_port;
	logic [7:0] out_port;
	logic [7:0] port_id;
	logic io_strb;

	logic [31:0] lcg_state;
	int cycle_count = 0;
	logic [17:0] prog_q[$];	// Program being assembled
	logic [7:0] exp_data_q[$];
	logic [7:0] exp_port_q[$];
	logic [7:0] got_data_q[$];
	logic [7:0] got_port_q[$];

	rat_cpu #(.PROG_ADDR_W(PROG_ADDR_W)) rat_cpu_inst (
		.CLK       (CLK),
		.RESET     (RESET),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.in_port   (in_port),
		.out_port  (out_port),
		.port_id   (port_id),
		.io_strb   (io_strb)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#CLK_HALF CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure($sformatf("Timeout, outputs missing after %0d cycles", cycle_count));
	end

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("sim failed");
		$fatal(1);
	endtask

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];	// Upper bits, better spread
	endfunction

	//////////////////////////////////////////////////
	// Assembler
	//////////////////////////////////////////////////
	function automatic logic [17:0] enc_rr(input logic [4:0] op_hi, input logic [4:0] rx,
		input logic [4:0] ry, input logic [1:0] op_lo);
		return {op_hi, rx, ry, 1'b0, op_lo};
	endfunction

	function automatic logic [17:0] enc_ri(input logic [4:0] op_hi, input logic [4:0] rx,
		input logic [7:0] imm);
		return {op_hi, rx, imm};
	endfunction

	function automatic logic [17:0] enc_br(input logic [4:0] op_hi, input logic [9:0] addr,
		input logic [1:0] op_lo);
		return {op_hi, addr, 1'b0, op_lo};
	endfunction

	function automatic logic [9:0] next_addr();
		return 10'(prog_q.size());
	endfunction

	task automatic add_instr(input logic [17:0] word);
		prog_q.push_back(word);
	endtask

	task automatic expect_out(input logic [7:0] data, input logic [7:0] port);
		exp_data_q.push_back(data);
		exp_port_q.push_back(port);
	endtask

	task automatic clear_program();
		prog_q.delete();
		exp_data_q.delete();
		exp_port_q.delete();
		got_data_q.delete();
		got_port_q.delete();
	endtask

	task automatic sample_strobe();
		@(negedge CLK);	// Mid-cycle, outputs settled
		if (io_strb)
		begin
			got_data_q.push_back(out_port);
			got_port_q.push_back(port_id);
		end
	endtask

	// Load under reset, release, capture strobes, compare
	task automatic run_program();
		logic [9:0] halt_addr;
		int n;
		halt_addr = next_addr();
		add_instr(enc_br(cpu_pkg::OP_BRANCH_A, halt_addr, 2'b00));	// BRN to itself
		@(negedge CLK);
		RESET = 1'b1;
		repeat (3)
			@(negedge CLK);
		foreach (prog_q[i])
		begin
			prog_we = 1'b1;
			prog_addr = PROG_ADDR_W'(i);
			prog_data = prog_q[i];
			@(negedge CLK);
			assert (!io_strb)
			else report_failure("io_strb high while the core is held in reset");
		end
		prog_we = 1'b0;
		RESET = 1'b0;
		n = exp_data_q.size();
		while (got_data_q.size() < n)
			sample_strobe();
		repeat (TAIL_CYCLES)
			sample_strobe();
		assert (got_data_q.size() == n)
		else report_failure($sformatf("ERROR io_strb count expected %h got %h",
			n, got_data_q.size()));
		foreach (exp_data_q[i])
		begin
			assert (got_data_q[i] == exp_data_q[i])
			else report_failure($sformatf("ERROR out_port strobe %0d expected %h got %h",
				i, exp_data_q[i], got_data_q[i]));
			assert (got_port_q[i] == exp_port_q[i])
			else report_failure($sformatf("ERROR port_id strobe %0d expected %h got %h",
				i, exp_port_q[i], got_port_q[i]));
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic test_mov_out();
		logic [7:0] val;
		logic [7:0] port;
		int k;
		clear_program();
		for (k = 1; k <= 3; k++)
		begin
			val = rand_byte();
			port = rand_byte();
			add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'(k), val));
			add_instr(enc_ri(cpu_pkg::OP_OUT, 5'(k), port));
			expect_out(val, port);
		end
		run_program();
		$display("test 1, MOV and OUT done");
	endtask

	// Carry chains from one op into the next
	task automatic test_arith();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] res;
		logic [7:0] tmp;
		logic [8:0] sum;
		logic [1:0] op;
		logic c;
		int i;
		clear_program();
		tmp = rand_byte();
		for (i = 0; i < 16; i++)
		begin
			op = i[1:0] ^ 2'b01;	// ADDC ADD SUBC SUB
			if (i % 8 == 0)
			begin
				c = tmp[0] ^ i[3];	// SEC or CLC first and the opposite one at i = 8
				add_instr(enc_rr(cpu_pkg::OP_CARRY, 5'd0, 5'd0, c ? 2'b01 : 2'b00));
			end
			a = rand_byte();
			b = rand_byte();
			add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd2, a));
			if (i[2])
				add_instr(enc_ri(ARITH_IMM_OPS[op], 5'd2, b));
			else
			begin
				add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd3, b));
				add_instr(enc_rr(cpu_pkg::OP_ARITH_RR, 5'd2, 5'd3, op));
			end
			add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd2, 8'(i)));
			if (!op[1])
			begin
				sum = 9'(a) + 9'(b) + 9'(op[0] & c);
				res = sum[7:0];
				c = (sum > 9'd255);	// Carry out
			end
			else
			begin
				sum = 9'(b) + 9'(op[0] & c);	// Total taken away
				res = a - sum[7:0];
				c = (9'(a) < sum);	// Borrow
			end
			expect_out(res, 8'(i));
		end
		run_program();
		$display("test 2, arithmetic done");
	endtask

	task automatic test_logic_shift();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] res;
		logic [1:0] op;
		logic c;
		int i;
		clear_program();
		for (i = 0; i < 6; i++)
		begin
			op = 2'(i % 3);	// AND OR EXOR
			a = rand_byte();
			b = rand_byte();
			add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd4, a));
			if (i >= 3)
				add_instr(enc_ri(LOGIC_IMM_OPS[op], 5'd4, b));
			else
			begin
				add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd5, b));
				add_instr(enc_rr(cpu_pkg::OP_LOGIC_RR, 5'd4, 5'd5, op));
			end
			add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd4, 8'(i)));
			case (op)
				2'd0: res = a & b;
				2'd1: res = a | b;
				default: res = a ^ b;
			endcase
			expect_out(res, 8'(i));
		end
		// TEST in both forms, register must survive
		a = rand_byte() | 8'h01;	// Nonzero so a & b differs from a
		b = ~a;
		add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd7, a));
		add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd8, b));
		add_instr(enc_rr(cpu_pkg::OP_LOGIC_RR, 5'd7, 5'd8, 2'b11));
		add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd7, 8'h30));
		add_instr(enc_ri(cpu_pkg::OP_TEST_I, 5'd7, b));
		add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd7, 8'h31));
		expect_out(a, 8'h30);
		expect_out(a, 8'h31);
		for (i = 0; i < 5; i++)	// LSL LSR ROL ROR ASR
		begin
			a = rand_byte();
			add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd6, a));
			if (i < 4)
				add_instr(enc_rr(cpu_pkg::OP_SHIFT_A, 5'd6, 5'd0, 2'(i)));
			else
				add_instr(enc_rr(cpu_pkg::OP_SHIFT_B, 5'd6, 5'd0, 2'b00));
			add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd6, 8'h40 + 8'(i)));
			// Carry copied into r9 by ADDC of zero
			add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd9, 8'h00));
			add_instr(enc_ri(cpu_pkg::OP_ADDC_I, 5'd9, 8'h00));
			add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd9, 8'h48 + 8'(i)));
			case (i)
				0: res = a << 1;
				1: res = a >> 1;
				2: res = (a << 1) | (a >> 7);
				3: res = (a >> 1) | (a << 7);
				default: res = (a >> 1) | (a & 8'h80);	// Sign bit stays
			endcase
			c = (i == 0 || i == 2) ? a[7] : a[0];	// Bit shifted out
			expect_out(res, 8'h40 + 8'(i));
			expect_out({7'd0, c}, 8'h48 + 8'(i));
		end
		run_program();
		$display("test 3, logic and shifts done");
	endtask

	// Conditional branch with one marker OUT on each path
	task automatic branch_block(input logic [4:0] op_hi, input logic [1:0] op_lo,
		input logic taken, input logic [7:0] tag);
		logic [9:0] base;
		base = next_addr();
		add_instr(enc_br(op_hi, base + 10'd4, op_lo));
		add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd12, tag | 8'h01));	// Fall-through marker
		add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd12, tag));
		add_instr(enc_br(cpu_pkg::OP_BRANCH_A, base + 10'd6, 2'b00));
		add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd12, tag | 8'h02));	// Taken marker
		add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd12, tag));
		expect_out(taken ? (tag | 8'h02) : (tag | 8'h01), tag);
	endtask

	task automatic test_branches();
		logic [7:0] a;
		logic [7:0] b;
		logic z;
		logic cb;
		logic [9:0] base;
		int k;
		clear_program();
		for (k = 0; k < 4; k++)
		begin
			a = rand_byte();
			case (k)
				0: b = a;	// Equal
				1:
				begin
					a = a >> 1;
					b = a | 8'h80;	// a below b
				end
				2:
				begin
					b = a >> 1;
					a = a | 8'h80;	// a above b
				end
				default: b = rand_byte();
			endcase
			add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd10, a));
			if (k[0])
				add_instr(enc_ri(cpu_pkg::OP_CMP_I, 5'd10, b));
			else
			begin
				add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd11, b));
				add_instr(enc_rr(cpu_pkg::OP_CMPMOV_RR, 5'd10, 5'd11, 2'b00));
			end
			z = (a == b);
			cb = (a < b);	// Borrow of a - b
			branch_block(cpu_pkg::OP_BRANCH_A, 2'b10, z, {2'b00, 2'(k), 2'd0, 2'b00});
			branch_block(cpu_pkg::OP_BRANCH_A, 2'b11, !z, {2'b00, 2'(k), 2'd1, 2'b00});
			branch_block(cpu_pkg::OP_BRANCH_B, 2'b00, cb, {2'b00, 2'(k), 2'd2, 2'b00});
			branch_block(cpu_pkg::OP_BRANCH_B, 2'b01, !cb, {2'b00, 2'(k), 2'd3, 2'b00});
		end
		// BRN over an OUT on an unused port
		base = next_addr();
		add_instr(enc_br(cpu_pkg::OP_BRANCH_A, base + 10'd2, 2'b00));
		add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd12, 8'hee));
		add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd12, 8'h5a));
		add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd12, 8'h5b));
		expect_out(8'h5a, 8'h5b);
		run_program();
		$display("test 4, branches done");
	endtask

	task automatic test_in_unknown();
		logic [7:0] v;
		clear_program();
		v = rand_byte();
		@(negedge CLK);
		in_port = rand_byte();	// Held for the whole run
		add_instr(enc_ri(cpu_pkg::OP_IN, 5'd14, 8'h21));
		add_instr(enc_rr(5'b11111, 5'd14, 5'd0, 2'b11));	// Undefined group, rx = r14
		add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd14, 8'h22));
		expect_out(in_port, 8'h22);
		add_instr(enc_ri(cpu_pkg::OP_MOV_I, 5'd15, v));
		add_instr(enc_rr(5'b01111, 5'd15, 5'd15, 2'b00));
		add_instr(enc_br(cpu_pkg::OP_BRANCH_A, 10'd0, 2'b01));	// CALL slot, not decoded
		add_instr(enc_ri(cpu_pkg::OP_OUT, 5'd15, 8'h23));
		expect_out(v, 8'h23);
		run_program();
		$display("test 5, IN and unknown opcodes done");
	endtask

	initial
	begin
		lcg_state = 32'hb7c1_2751;
		RESET = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		in_port = 8'h00;
		repeat (3)
			@(negedge CLK);
		test_mov_out();
		test_arith();
		test_logic_shift();
		test_branches();
		test_in_unknown();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
src/cpu_pkg.sv
src/cpu_ctrl_if.sv
src/control_unit.sv
src/program_counter.sv
src/prog_mem.sv
src/reg_file.sv
src/alu_unit.sv
src/rat_cpu.sv
testbench/rat_cpu_tb.sv

// File: Makefile
# Verilator build and run of the rat_cpu testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module rat_cpu_tb \
		-Mdir obj_dir -o Vrat_cpu_tb

# The log decides the result
run: compile
	./obj_dir/Vrat_cpu_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
